// ==== tb.f ====
+incdir+logic
logic/caster_pkg.sv
logic/scan_timing.sv
logic/wvfm_addr_stage.sv
logic/wvfm_lut.sv
logic/pixel_writeback_stage.sv
logic/caster_top.sv
dv/caster_props.sv
dv/caster_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := caster_tb
FILELIST := tb.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/caster_tb.sv ====
/* Caster core testbench */

`timescale 1ns/1ps
`default_nettype none

`include "caster_params.svh"

module caster_tb;

    localparam int CLK_PERIOD = 20;
    localparam int HFP = 2, HSYNC = 2, HBP = 4, HACT = 4;
    localparam int VFP = 1, VSYNC = 1, VBP = 1, VACT = 2;
    localparam int H_TOTAL = HFP + HSYNC + HBP + HACT;
    localparam int V_TOTAL = VFP + VSYNC + VBP + VACT;
    localparam logic [`SEQ_W-1:0] LUT_FRAMES = 5;
    localparam int N_FRAMES = 7;
    localparam int BEATS = VACT * HACT;
    localparam int TOTAL = N_FRAMES * BEATS;
    localparam int LUT_BYTES = 1 << `LUT_WAW;
    // Idle, waiting and one raster
    localparam int FRAME_CYCLES = 1 + (`VS_DELAY + 1)
        + (VFP + VSYNC + VBP + VACT) * (HFP + HSYNC + HBP + HACT);
    localparam int WATCHDOG_CYCLES = 3 + LUT_BYTES + N_FRAMES * FRAME_CYCLES + 200;

    logic clk = 1'b0;
    logic rst;
    logic vin_vsync, sys_ready, global_en;
    logic [`PORCH_W-1:0] vfp, vsync, vbp, hfp, hsync, hbp;
    logic [`CNT_W-1:0] vact, hact;
    logic [`SEQ_W-1:0] lut_frames;
    logic lut_we;
    logic [`LUT_WAW-1:0] lut_addr;
    logic [7:0] lut_wdata;
    logic [`STATE_W*`PIX_PER_CLK-1:0] bi_pixel;
    logic bi_valid;
    wire bi_ready, bo_valid, b_trigger;
    wire [`STATE_W*`PIX_PER_CLK-1:0] bo_pixel;
    wire [15:0] epd_sd;
    wire epd_gdclk, epd_gdsp, epd_sdle, epd_sdce0, epd_sdclk;

    // One row per frame, first beat words and the underrun beat
    logic [63:0] first_beat [N_FRAMES];
    int kill_beat [N_FRAMES];

    logic [15:0] exp_sd_q [$];
    logic [63:0] exp_pix_q [$];
    logic [15:0] want_sd;
    logic [63:0] want_pix;
    integer seed = 65;
    int errors = 0;
    int bo_seen = 0;
    int frame_beats = 0;
    int frames_started = 0;
    logic started = 1'b0;
    logic trigger_seen = 1'b0;
    logic trigger_prev = 1'b0;

    // Raster position mirrored from the trigger's falling edge
    logic in_frame = 1'b0;
    logic gdclk_want = 1'b0;
    int col = 0;
    int row = 0;
    int trig_len = 0;

    caster_top caster_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Sum of all bit pairs, so every address bit matters
    function automatic logic [1:0] lut_entry(input logic [`LUT_AW-1:0] a);
        logic [1:0] s;
        s = '0;
        for (int i = 0; i < `LUT_AW; i += 2) begin
            s = s + a[i +: 2];
        end
        return s;
    endfunction

    function automatic logic [15:0] pix_word(input logic [3:0] src, input logic [5:0] cnt,
                                             input logic [3:0] tgt);
        return {2'b00, src, cnt, tgt};
    endfunction

    function automatic logic [15:0] auto_word(input logic [3:0] src, input logic [3:0] tgt);
        return {1'b1, 7'd0, src, tgt};
    endfunction

    function automatic logic [1:0] expected_drive(input logic [15:0] word,
                                                  input logic [5:0] shared_cnt,
                                                  input logic alive);
        caster_pkg::fb_state_u w;
        logic [5:0] seq;
        w = word;
        if (!alive) return 2'b00;
        if (w.pix.mode) begin
            seq = LUT_FRAMES - shared_cnt;
            return lut_entry({seq, w.alut.tgt, w.alut.src});
        end
        if (w.pix.cnt == 0) return 2'b00;
        seq = LUT_FRAMES - w.pix.cnt;
        return lut_entry({seq, w.pix.tgt, w.pix.src});
    endfunction

    function automatic logic [15:0] expected_word(input logic [15:0] word,
                                                  input logic [5:0] shared_cnt,
                                                  input logic alive);
        caster_pkg::fb_state_u w;
        w = word;
        if (!alive) return word;
        if (w.pix.mode) begin
            if (shared_cnt == 0) w.alut.src = w.alut.tgt;
        end else if (w.pix.cnt != 0) begin
            if (w.pix.cnt == 1) w.pix.src = w.pix.tgt;
            w.pix.cnt = w.pix.cnt - 1'b1;
        end
        return w;
    endfunction

    task automatic push_expected(input logic [63:0] words, input logic [5:0] shared_cnt,
                                 input logic alive);
        logic [15:0] sd;
        logic [63:0] pix;
        sd = '0;
        for (int i = 0; i < `PIX_PER_CLK; i++) begin
            sd[i*2 +: 2] = expected_drive(words[i*16 +: 16], shared_cnt, alive);
            pix[i*16 +: 16] = expected_word(words[i*16 +: 16], shared_cnt, alive);
        end
        exp_sd_q.push_back(sd);
        exp_pix_q.push_back(pix);
    endtask

    task automatic load_stimulus;
        first_beat[0] = {auto_word(4, 9), pix_word(7, 0, 1), pix_word(2, 1, 12),
                         pix_word(3, 3, 10)};
        kill_beat[0] = -1;
        first_beat[1] = {pix_word(0, 2, 8), pix_word(15, 1, 0), auto_word(6, 2),
                         pix_word(1, 5, 14)};
        kill_beat[1] = 3;
        first_beat[2] = {pix_word(9, 1, 3), pix_word(5, 0, 5), auto_word(11, 13),
                         pix_word(8, 4, 2)};
        kill_beat[2] = -1;
        first_beat[3] = {auto_word(1, 15), auto_word(0, 7), pix_word(6, 6, 6),
                         pix_word(12, 1, 4)};
        kill_beat[3] = -1;
        first_beat[4] = {pix_word(3, 0, 3), pix_word(10, 2, 11), auto_word(2, 14),
                         auto_word(13, 5)};
        kill_beat[4] = -1;
        // Shared counter is 0 in this frame
        first_beat[5] = {auto_word(8, 1), auto_word(14, 3), pix_word(4, 1, 9),
                         auto_word(5, 12)};
        kill_beat[5] = 6;
        first_beat[6] = {auto_word(7, 0), pix_word(2, 1, 7), pix_word(11, 3, 1),
                         auto_word(9, 6)};
        kill_beat[6] = -1;
    endtask

    task automatic fill_table;
        logic [7:0] data;
        for (int b = 0; b < LUT_BYTES; b++) begin
            for (int k = 0; k < 4; k++) begin
                data[k*2 +: 2] = lut_entry({b[`LUT_WAW-1:0], k[1:0]});
            end
            @(posedge clk);
            #2;
            lut_we = 1'b1;
            lut_addr = b[`LUT_WAW-1:0];
            lut_wdata = data;
        end
        @(posedge clk);
        #2;
        lut_we = 1'b0;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        errors++;
        $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
    endtask

    // Driver strobes against the mirrored raster
    task automatic check_strobes;
        logic sdle_want;
        logic gdsp_want;
        logic sdce0_want;
        sdle_want = in_frame && col >= HFP && col < HFP + HSYNC;
        gdsp_want = !(in_frame && row >= VFP && row < VFP + VSYNC);
        sdce0_want = !(in_frame && row >= VFP + VSYNC + VBP && col >= HFP + HSYNC + HBP);
        if (epd_sdle !== sdle_want) report_mismatch("epd_sdle", epd_sdle, sdle_want);
        if (epd_gdsp !== gdsp_want) report_mismatch("epd_gdsp", epd_gdsp, gdsp_want);
        if (epd_sdce0 !== sdce0_want) report_mismatch("epd_sdce0", epd_sdce0, sdce0_want);
        if (epd_gdclk !== gdclk_want) report_mismatch("epd_gdclk", epd_gdclk, gdclk_want);
        // Gate clock shows this column one cycle later
        gdclk_want = in_frame && col >= HFP;
    endtask

    task automatic advance_raster;
        if (in_frame) begin
            if (col == H_TOTAL - 1) begin
                col = 0;
                if (row == V_TOTAL - 1) begin
                    in_frame = 1'b0;
                end else begin
                    row++;
                end
            end else begin
                col++;
            end
        end
    endtask

    // Output checks away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            if (!started && (bi_ready || bo_valid || b_trigger)) begin
                errors++;
                $display("Scan became active before the start condition at %0t", $time);
            end
            if (b_trigger) trigger_seen = 1'b1;
            if (bi_ready && !trigger_seen) begin
                errors++;
                $display("bi_ready rose before any b_trigger at %0t", $time);
            end
            if (b_trigger && !trigger_prev) begin
                if (frames_started > 0 && frame_beats != BEATS) begin
                    errors++;
                    $display("Frame %0d gave %0d output beats", frames_started, frame_beats);
                end
                frame_beats = 0;
                frames_started++;
            end
            if (!b_trigger && trigger_prev) begin
                if (trig_len != `VS_DELAY + 1) begin
                    errors++;
                    $display("b_trigger stayed high for %0d cycles at %0t", trig_len, $time);
                end
                trig_len = 0;
                in_frame = 1'b1;
                col = 0;
                row = 0;
            end
            if (b_trigger) trig_len++;
            check_strobes();
            advance_raster();
            trigger_prev = b_trigger;
            if (epd_sdce0 !== !bo_valid) report_mismatch("epd_sdce0", epd_sdce0, !bo_valid);
            if (bo_valid) begin
                frame_beats++;
                bo_seen++;
                if (exp_sd_q.size() == 0) begin
                    errors++;
                    $display("bo_valid beat with no input beat behind it at %0t", $time);
                end else begin
                    want_sd = exp_sd_q.pop_front();
                    want_pix = exp_pix_q.pop_front();
                    if (epd_sd !== want_sd) report_mismatch("epd_sd", epd_sd, want_sd);
                    if (bo_pixel !== want_pix) report_mismatch("bo_pixel", bo_pixel, want_pix);
                end
            end
        end
    end

    // Source clock is the inverted clock, looked at mid phase
    always @(clk) begin
        #(CLK_PERIOD / 4);
        if (epd_sdclk !== !clk) report_mismatch("epd_sdclk", epd_sdclk, !clk);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the frames did not complete", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [63:0] next_word;
        logic [5:0] shared_cnt;
        logic alive;
        logic pending;
        int sent;
        int beat;
        int frame;
        rst = 1'b1;
        // Start held off by each enable in turn
        vin_vsync = 1'b1;
        sys_ready = 1'b1;
        global_en = 1'b0;
        vfp = VFP;
        vsync = VSYNC;
        vbp = VBP;
        vact = VACT;
        hfp = HFP;
        hsync = HSYNC;
        hbp = HBP;
        hact = HACT;
        lut_frames = LUT_FRAMES;
        lut_we = 1'b0;
        lut_addr = '0;
        lut_wdata = '0;
        bi_pixel = '0;
        bi_valid = 1'b0;
        shared_cnt = '0;
        alive = 1'b1;
        pending = 1'b0;
        next_word = '0;
        sent = 0;
        load_stimulus();
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        fill_table();
        global_en = 1'b1;
        sys_ready = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        sys_ready = 1'b1;
        started = 1'b1;
        // Data follows its ready beat by one cycle
        while (sent < TOTAL || pending) begin
            @(posedge clk);
            #2;
            bi_pixel = pending ? next_word : '0;
            pending = 1'b0;
            bi_valid = 1'b0;
            if (bi_ready && sent < TOTAL) begin
                beat = sent % BEATS;
                frame = sent / BEATS;
                if (beat == 0) begin
                    alive = 1'b1;
                    shared_cnt = (shared_cnt == 0) ? LUT_FRAMES : shared_cnt - 1'b1;
                end
                if (beat == kill_beat[frame]) alive = 1'b0;
                next_word = (beat == 0) ? first_beat[frame] : {$random(seed), $random(seed)};
                bi_valid = (beat != kill_beat[frame]);
                push_expected(next_word, shared_cnt, alive);
                pending = 1'b1;
                sent++;
                if (sent == TOTAL) vin_vsync = 1'b0;
            end
        end
        wait (bo_seen >= TOTAL);
        repeat (FRAME_CYCLES) @(posedge clk);
        if (bo_seen != TOTAL || frame_beats != BEATS || frames_started != N_FRAMES) begin
            errors++;
            $display("Saw %0d beats over %0d frames", bo_seen, frames_started);
        end
        $display("Run summary: %0d errors, %0d output beats", errors, bo_seen);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/caster_props.sv ====
/* Handshake timing assertions */

`timescale 1ns/1ps
`default_nettype none

`include "caster_params.svh"

module caster_props (
    input wire clk,
    input wire rst,
    input wire bi_ready,
    input wire bo_valid,
    input wire b_trigger,
    input wire epd_sdce0
);

    // Output beat lands a fixed pipeline depth after its ready
    ready_to_valid: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, `PIPE_LEAD) |-> (bo_valid == $past(bi_ready, `PIPE_LEAD)))
        else $error("bo_valid does not trail bi_ready by %0d cycles", `PIPE_LEAD);

    trigger_not_ready: assert property (@(posedge clk) disable iff (rst)
        !(b_trigger && bi_ready))
        else $error("b_trigger and bi_ready high in the same cycle");

    // Source enable is active low over the window
    sdce0_window: assert property (@(posedge clk) disable iff (rst)
        epd_sdce0 == !bo_valid)
        else $error("epd_sdce0 is not the inverse of bo_valid");

endmodule

bind caster_top caster_props caster_props_i (
    .clk(clk),
    .rst(rst),
    .bi_ready(bi_ready),
    .bo_valid(bo_valid),
    .b_trigger(b_trigger),
    .epd_sdce0(epd_sdce0)
);

`default_nettype wire

// ==== logic/caster_top.sv ====
/* EPD scan and waveform core */

`timescale 1ns/1ps
`default_nettype none

`include "caster_params.svh"

module caster_top (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 vin_vsync,
    input  wire                                 sys_ready,
    input  wire                                 global_en,
    input  wire [`PORCH_W-1:0]                  vfp,
    input  wire [`PORCH_W-1:0]                  vsync,
    input  wire [`PORCH_W-1:0]                  vbp,
    input  wire [`CNT_W-1:0]                    vact,
    input  wire [`PORCH_W-1:0]                  hfp,
    input  wire [`PORCH_W-1:0]                  hsync,
    input  wire [`PORCH_W-1:0]                  hbp,
    input  wire [`CNT_W-1:0]                    hact,
    input  wire [`SEQ_W-1:0]                    lut_frames,
    input  wire                                 lut_we,
    input  wire [`LUT_WAW-1:0]                  lut_addr,
    input  wire [7:0]                           lut_wdata,
    input  wire [`STATE_W*`PIX_PER_CLK-1:0]     bi_pixel,
    input  wire                                 bi_valid,
    output wire                                 bi_ready,
    output wire [`STATE_W*`PIX_PER_CLK-1:0]     bo_pixel,
    output wire                                 bo_valid,
    output wire [15:0]                          epd_sd,
    output wire                                 epd_gdclk,
    output wire                                 epd_gdsp,
    output wire                                 epd_sdle,
    output wire                                 epd_sdce0,
    output wire                                 epd_sdclk,
    output wire                                 b_trigger
);

    wire                                ready_ok;
    wire [`SEQ_W-1:0]                   auto_cnt;
    wire [`LUT_AW-1:0]                  rd_addr0;
    wire [`LUT_AW-1:0]                  rd_addr1;
    wire [`LUT_AW-1:0]                  rd_addr2;
    wire [`LUT_AW-1:0]                  rd_addr3;
    wire [`STATE_W*`PIX_PER_CLK-1:0]    words;
    wire                                seq_ok;
    wire                                seq_valid;
    wire [`DRIVE_W*`PIX_PER_CLK-1:0]    rd_drive;

    scan_timing scan_timing_i (
        .clk(clk), .rst(rst),
        .vin_vsync(vin_vsync), .sys_ready(sys_ready), .global_en(global_en),
        .vfp(vfp), .vsync(vsync), .vbp(vbp), .vact(vact),
        .hfp(hfp), .hsync(hsync), .hbp(hbp), .hact(hact),
        .lut_frames(lut_frames), .bi_valid(bi_valid),
        .bi_ready(bi_ready), .ready_ok(ready_ok), .auto_cnt(auto_cnt),
        .b_trigger(b_trigger), .epd_gdclk(epd_gdclk), .epd_gdsp(epd_gdsp),
        .epd_sdle(epd_sdle), .epd_sdce0(epd_sdce0), .epd_sdclk(epd_sdclk)
    );

    wvfm_addr_stage wvfm_addr_stage_i (
        .clk(clk), .rst(rst),
        .bi_ready(bi_ready), .ready_ok(ready_ok), .bi_pixel(bi_pixel),
        .auto_cnt(auto_cnt), .lut_frames(lut_frames),
        .rd_addr0(rd_addr0), .rd_addr1(rd_addr1),
        .rd_addr2(rd_addr2), .rd_addr3(rd_addr3),
        .words(words), .seq_ok(seq_ok), .seq_valid(seq_valid)
    );

    wvfm_lut wvfm_lut_i (
        .clk(clk),
        .lut_we(lut_we), .lut_addr(lut_addr), .lut_wdata(lut_wdata),
        .rd_addr0(rd_addr0), .rd_addr1(rd_addr1),
        .rd_addr2(rd_addr2), .rd_addr3(rd_addr3),
        .rd_drive(rd_drive)
    );

    pixel_writeback_stage pixel_writeback_stage_i (
        .clk(clk), .rst(rst),
        .rd_drive(rd_drive), .words_in(words),
        .seq_ok(seq_ok), .seq_valid(seq_valid), .auto_cnt(auto_cnt),
        .epd_sd(epd_sd), .bo_pixel(bo_pixel), .bo_valid(bo_valid)
    );

endmodule

`default_nettype wire

// ==== logic/pixel_writeback_stage.sv ====
/* Pixel drive and state writeback */

`timescale 1ns/1ps
`default_nettype none

`include "caster_params.svh"

module pixel_writeback_stage (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire [`DRIVE_W*`PIX_PER_CLK-1:0]     rd_drive,
    input  wire [`STATE_W*`PIX_PER_CLK-1:0]     words_in,
    input  wire                                 seq_ok,
    input  wire                                 seq_valid,
    input  wire [`SEQ_W-1:0]                    auto_cnt,
    output logic [15:0]                         epd_sd,
    output logic [`STATE_W*`PIX_PER_CLK-1:0]    bo_pixel,
    output logic                                bo_valid
);

    // Aligned with the table output
    logic [`STATE_W*`PIX_PER_CLK-1:0] words_d;
    logic ok_d;
    logic valid_d;

    logic [`DRIVE_W*`PIX_PER_CLK-1:0] drive_nxt;
    logic [`STATE_W*`PIX_PER_CLK-1:0] words_nxt;

    always_comb begin
        caster_pkg::fb_state_u w;
        caster_pkg::fb_state_u nw;
        logic [`DRIVE_W-1:0] drv;
        for (int i = 0; i < `PIX_PER_CLK; i++) begin
            w   = words_d[i*`STATE_W +: `STATE_W];
            nw  = w;
            drv = rd_drive[i*`DRIVE_W +: `DRIVE_W];
            if (!w.pix.mode) begin
                if (w.pix.cnt == '0) begin
                    // Transition finished, pixel idles
                    drv = '0;
                end else begin
                    nw.pix.cnt = w.pix.cnt - 1'b1;
                    if (w.pix.cnt == `SEQ_W'(1)) begin
                        nw.pix.src = w.pix.tgt;
                    end
                end
            end else if (auto_cnt == '0) begin
                nw.alut.src = w.alut.tgt;
            end
            // Killed frame, state passes through
            if (!ok_d) begin
                drv = '0;
                nw  = w;
            end
            drive_nxt[i*`DRIVE_W +: `DRIVE_W] = drv;
            words_nxt[i*`STATE_W +: `STATE_W] = nw;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d  <= 1'b0;
            bo_valid <= 1'b0;
        end else begin
            valid_d  <= seq_valid;
            bo_valid <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        words_d  <= words_in;
        ok_d     <= seq_ok;
        bo_pixel <= words_nxt;
        epd_sd   <= valid_d ? {{(16 - `DRIVE_W*`PIX_PER_CLK){1'b0}}, drive_nxt} : '0;
    end

endmodule

`default_nettype wire

// ==== logic/wvfm_lut.sv ====
/* Waveform lookup table */

`timescale 1ns/1ps
`default_nettype none

`include "caster_params.svh"

module wvfm_lut (
    input  wire                                 clk,
    input  wire                                 lut_we,
    input  wire [`LUT_WAW-1:0]                  lut_addr,
    input  wire [7:0]                           lut_wdata,
    input  wire [`LUT_AW-1:0]                   rd_addr0,
    input  wire [`LUT_AW-1:0]                   rd_addr1,
    input  wire [`LUT_AW-1:0]                   rd_addr2,
    input  wire [`LUT_AW-1:0]                   rd_addr3,
    output logic [`DRIVE_W*`PIX_PER_CLK-1:0]    rd_drive
);

    // Entries packed into one write byte
    localparam int SUB_W = `LUT_AW - `LUT_WAW;
    localparam int DEPTH = 1 << `LUT_AW;

    logic [`DRIVE_W-1:0] mem [DEPTH];

    // Bit pair k lands at {lut_addr, k}
    always_ff @(posedge clk) begin
        if (lut_we) begin
            for (int k = 0; k < (1 << SUB_W); k++) begin
                mem[{lut_addr, SUB_W'(k)}] <= lut_wdata[k*`DRIVE_W +: `DRIVE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_drive[0*`DRIVE_W +: `DRIVE_W] <= mem[rd_addr0];
        rd_drive[1*`DRIVE_W +: `DRIVE_W] <= mem[rd_addr1];
        rd_drive[2*`DRIVE_W +: `DRIVE_W] <= mem[rd_addr2];
        rd_drive[3*`DRIVE_W +: `DRIVE_W] <= mem[rd_addr3];
    end

endmodule

`default_nettype wire

// ==== logic/wvfm_addr_stage.sv ====
/* Waveform address stage */

`timescale 1ns/1ps
`default_nettype none

`include "caster_params.svh"

module wvfm_addr_stage (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 bi_ready,
    input  wire                                 ready_ok,
    input  wire [`STATE_W*`PIX_PER_CLK-1:0]     bi_pixel,
    input  wire [`SEQ_W-1:0]                    auto_cnt,
    input  wire [`SEQ_W-1:0]                    lut_frames,
    output logic [`LUT_AW-1:0]                  rd_addr0,
    output logic [`LUT_AW-1:0]                  rd_addr1,
    output logic [`LUT_AW-1:0]                  rd_addr2,
    output logic [`LUT_AW-1:0]                  rd_addr3,
    output logic [`STATE_W*`PIX_PER_CLK-1:0]    words,
    output logic                                seq_ok,
    output logic                                seq_valid
);

    // Stream data lags ready by one cycle
    logic ready_d;
    logic ok_d;
    logic [`LUT_AW-1:0] addr_d [`PIX_PER_CLK];

    always_comb begin
        caster_pkg::fb_state_u w;
        logic [`SEQ_W-1:0] cnt;
        logic [`GRAY_W-1:0] src;
        for (int i = 0; i < `PIX_PER_CLK; i++) begin
            w = bi_pixel[i*`STATE_W +: `STATE_W];
            if (w.alut.mode) begin
                cnt = auto_cnt;
                src = w.alut.src;
            end else begin
                cnt = w.pix.cnt;
                src = w.pix.src;
            end
            // Target is the low nibble in both views
            addr_d[i] = {lut_frames - cnt, w.pix.tgt, src};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_d   <= 1'b0;
            seq_valid <= 1'b0;
        end else begin
            ready_d   <= bi_ready;
            seq_valid <= ready_d;
        end
    end

    always_ff @(posedge clk) begin
        ok_d     <= ready_ok;
        seq_ok   <= ok_d;
        words    <= bi_pixel;
        rd_addr0 <= addr_d[0];
        rd_addr1 <= addr_d[1];
        rd_addr2 <= addr_d[2];
        rd_addr3 <= addr_d[3];
    end

endmodule

`default_nettype wire

// ==== logic/scan_timing.sv ====
/* EPD scan timing and driver strobes */

`timescale 1ns/1ps
`default_nettype none

`include "caster_params.svh"

module scan_timing (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 vin_vsync,
    input  wire                 sys_ready,
    input  wire                 global_en,
    input  wire [`PORCH_W-1:0]  vfp,
    input  wire [`PORCH_W-1:0]  vsync,
    input  wire [`PORCH_W-1:0]  vbp,
    input  wire [`CNT_W-1:0]    vact,
    input  wire [`PORCH_W-1:0]  hfp,
    input  wire [`PORCH_W-1:0]  hsync,
    input  wire [`PORCH_W-1:0]  hbp,
    input  wire [`CNT_W-1:0]    hact,
    input  wire [`SEQ_W-1:0]    lut_frames,
    input  wire                 bi_valid,
    output logic                bi_ready,
    output logic                ready_ok,
    output logic [`SEQ_W-1:0]   auto_cnt,
    output logic                b_trigger,
    output logic                epd_gdclk,
    output logic                epd_gdsp,
    output logic                epd_sdle,
    output logic                epd_sdce0,
    output logic                epd_sdclk
);

    caster_pkg::scan_state_e state;
    logic [`CNT_W-1:0] h_cnt;
    logic [`CNT_W-1:0] v_cnt;
    // Cleared on underrun, masks the rest of the frame
    logic frame_ok;

    logic [`CNT_W-1:0] v_sync_start;
    logic [`CNT_W-1:0] v_bp_start;
    logic [`CNT_W-1:0] v_act_start;
    logic [`CNT_W-1:0] v_total;
    logic [`CNT_W-1:0] h_sync_start;
    logic [`CNT_W-1:0] h_bp_start;
    logic [`CNT_W-1:0] h_act_start;
    logic [`CNT_W-1:0] h_total;
    logic [`CNT_W-1:0] rdy_start;
    logic [`CNT_W-1:0] rdy_end;

    logic running;
    logic in_vsync;
    logic in_vact;
    logic in_hsync;
    logic in_hbp;
    logic in_hact;

    // Region boundaries, order is fp, sync, bp, act
    assign v_sync_start = `CNT_W'(vfp);
    assign v_bp_start   = v_sync_start + `CNT_W'(vsync);
    assign v_act_start  = v_bp_start + `CNT_W'(vbp);
    assign v_total      = v_act_start + vact;
    assign h_sync_start = `CNT_W'(hfp);
    assign h_bp_start   = h_sync_start + `CNT_W'(hsync);
    assign h_act_start  = h_bp_start + `CNT_W'(hbp);
    assign h_total      = h_act_start + hact;

    // Ready window opens early to cover the pipeline
    assign rdy_start = h_act_start - `CNT_W'(`PIPE_LEAD);
    assign rdy_end   = h_total - `CNT_W'(`PIPE_LEAD);

    assign running  = (state == caster_pkg::SCAN_RUNNING);
    assign in_vsync = running && (v_cnt >= v_sync_start) && (v_cnt < v_bp_start);
    assign in_vact  = running && (v_cnt >= v_act_start);
    assign in_hsync = running && (h_cnt >= h_sync_start) && (h_cnt < h_bp_start);
    assign in_hbp   = running && (h_cnt >= h_bp_start) && (h_cnt < h_act_start);
    assign in_hact  = running && (h_cnt >= h_act_start);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= caster_pkg::SCAN_IDLE;
            h_cnt    <= '0;
            v_cnt    <= '0;
            auto_cnt <= '0;
            frame_ok <= 1'b0;
        end else begin
            case (state)
                caster_pkg::SCAN_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (sys_ready && global_en && vin_vsync) begin
                        state <= caster_pkg::SCAN_WAITING;
                    end
                end
                caster_pkg::SCAN_WAITING: begin
                    // h_cnt doubles as the wait timer
                    if (h_cnt == `CNT_W'(`VS_DELAY)) begin
                        state    <= caster_pkg::SCAN_RUNNING;
                        h_cnt    <= '0;
                        frame_ok <= 1'b1;
                        if (auto_cnt == '0) begin
                            auto_cnt <= lut_frames;
                        end else begin
                            auto_cnt <= auto_cnt - 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                end
                caster_pkg::SCAN_RUNNING: begin
                    if (h_cnt == h_total - 1'b1) begin
                        h_cnt <= '0;
                        if (v_cnt == v_total - 1'b1) begin
                            state <= caster_pkg::SCAN_IDLE;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 1'b1;
                    end
                    if (bi_ready && !bi_valid) begin
                        frame_ok <= 1'b0;
                    end
                end
                default: state <= caster_pkg::SCAN_IDLE;
            endcase
        end
    end

    // Gate clock trails the sync, bp and act columns by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            epd_gdclk <= 1'b0;
        end else begin
            epd_gdclk <= in_hsync || in_hbp || in_hact;
        end
    end

    assign bi_ready  = in_vact && (h_cnt >= rdy_start) && (h_cnt < rdy_end);
    // An underrun beat is already killed
    assign ready_ok  = frame_ok && bi_valid;
    assign b_trigger = (state == caster_pkg::SCAN_WAITING);
    assign epd_sdle  = in_hsync;
    assign epd_gdsp  = !in_vsync;
    assign epd_sdce0 = !(in_vact && in_hact);
    assign epd_sdclk = ~clk;

endmodule

`default_nettype wire

// ==== logic/caster_pkg.sv ====
/* Caster shared types */

`default_nettype none

`include "caster_params.svh"

package caster_pkg;

    typedef enum logic [1:0] {
        SCAN_IDLE    = 2'd0,
        SCAN_WAITING = 2'd1,
        SCAN_RUNNING = 2'd2
    } scan_state_e;

    // Per-pixel mode, the word carries its own frame counter
    typedef struct packed {
        logic               mode;
        logic               rsvd;
        logic [`GRAY_W-1:0] src;
        logic [`SEQ_W-1:0]  cnt;
        logic [`GRAY_W-1:0] tgt;
    } fb_pixel_t;

    // Auto mode, frame count comes from the shared counter
    typedef struct packed {
        logic                                 mode;
        logic [`STATE_W-2*`GRAY_W-2:0]        rsvd;
        logic [`GRAY_W-1:0]                   src;
        logic [`GRAY_W-1:0]                   tgt;
    } fb_auto_t;

    // Same word, decoded by its top bit
    typedef union packed {
        fb_pixel_t pix;
        fb_auto_t  alut;
    } fb_state_u;

endpackage

`default_nettype wire

// ==== logic/caster_params.svh ====
/* Caster sizes and timing constants */

`ifndef CASTER_PARAMS_SVH
`define CASTER_PARAMS_SVH

// Raster counters and porch inputs
`define CNT_W 11
`define PORCH_W 8

// Framebuffer stream, 4 state words per clock
`define PIX_PER_CLK 4
`define STATE_W 16
`define DRIVE_W 2
`define GRAY_W 4
`define SEQ_W 6

// Waveform table, read address is {seq, target, source}
`define LUT_AW 14
`define LUT_WAW 12

// Scan timing
`define VS_DELAY 8
// Equals the register depth from bi_ready to bo_valid
`define PIPE_LEAD 4

`endif
